//--- hdl/vmul_consts.svh
/* vector multiplier constants
   data and address widths, piece sizes and pipeline depth */

`ifndef VMUL_CONSTS_SVH
`define VMUL_CONSTS_SVH

// vector and destination address
`define VMUL_DATA_W 64
`define VMUL_ADDR_W 32

// 16-bit piece plus its extension bit
`define VMUL_PIECE_W 17
`define VMUL_NUM_PIECES 4

// byte lanes, 8 bits plus extension
`define VMUL_NUM_BYTES 8
`define VMUL_BYTE_OP_W 9

// input edge to output register
`define VMUL_LATENCY 4

`endif

//--- hdl/vmul_pkg.sv
/* vector multiplier types
   opcodes, element widths and the structs passed between stages */

`include "vmul_consts.svh"

package vmul_pkg;

	typedef enum logic [1:0] {
		SEW_8  = 2'd0,
		SEW_16 = 2'd1,
		SEW_32 = 2'd2,
		SEW_64 = 2'd3 // reserved, never valid here
	} sew_e;

	typedef enum logic [1:0] {
		OP_MUL    = 2'd0, // low half
		OP_MULH   = 2'd1, // signed x signed, high half
		OP_MULHSU = 2'd2, // signed x unsigned, high half
		OP_MULHU  = 2'd3  // unsigned x unsigned, high half
	} mul_op_e;

	typedef struct packed {
		logic [`VMUL_DATA_W-1:0] vec0;
		logic [`VMUL_DATA_W-1:0] vec1;
		sew_e                    sew;
		mul_op_e                 op;
		logic [`VMUL_ADDR_W-1:0] addr;
	} mul_req_t;

	typedef struct packed {
		logic                    valid;
		sew_e                    sew;
		mul_op_e                 op;
		logic [`VMUL_ADDR_W-1:0] addr;
	} mul_tag_t;

	typedef struct packed {
		logic [`VMUL_NUM_PIECES-1:0][`VMUL_PIECE_W-1:0]  a;
		logic [`VMUL_NUM_PIECES-1:0][`VMUL_PIECE_W-1:0]  b;
		logic [`VMUL_NUM_BYTES-1:0][`VMUL_BYTE_OP_W-1:0] byte_a;
		logic [`VMUL_NUM_BYTES-1:0][`VMUL_BYTE_OP_W-1:0] byte_b;
	} piece_ops_t;

	typedef struct packed {
		logic [`VMUL_NUM_BYTES-1:0][15:0]    byte_prod;
		logic [`VMUL_NUM_PIECES-1:0][31:0]   half_prod;
		logic [`VMUL_NUM_PIECES/2-1:0][63:0] word_prod;
	} product_vec_t;

endpackage

//--- hdl/operand_select.sv
/* operand select stage
   splits both operands into 16-bit and 8-bit pieces, extends each one
   by sign or zero according to opcode and element width, then registers */

`timescale 1ns/1ps
`include "vmul_consts.svh"

module operand_select import vmul_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  mul_req_t   req,
	output piece_ops_t ops,
	output mul_tag_t   tag
);

	logic       a_sgn;
	logic       b_sgn;
	piece_ops_t ops_d;

	// vec0 is the signed side of mulhsu
	assign a_sgn = (req.op == OP_MULH) || (req.op == OP_MULHSU);
	assign b_sgn = (req.op == OP_MULH);

	always_comb begin
		logic [15:0] pa;
		logic [15:0] pb;
		logic [7:0]  ba;
		logic [7:0]  bb;
		logic        top_piece;

		for (int i = 0; i < `VMUL_NUM_PIECES; i++) begin
			pa = req.vec0[16*i +: 16];
			pb = req.vec1[16*i +: 16];
			// lower half of a 32-bit element carries no sign
			top_piece = (req.sew != SEW_32) || (i % 2 == 1);
			ops_d.a[i] = {top_piece & a_sgn & pa[15], pa};
			ops_d.b[i] = {top_piece & b_sgn & pb[15], pb};
		end

		for (int j = 0; j < `VMUL_NUM_BYTES; j++) begin
			ba = req.vec0[8*j +: 8];
			bb = req.vec1[8*j +: 8];
			ops_d.byte_a[j] = {a_sgn & ba[7], ba};
			ops_d.byte_b[j] = {b_sgn & bb[7], bb};
		end
	end

	always_ff @(posedge clk) begin
		ops <= ops_d; // payload, no reset
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tag <= '0;
		end else begin
			tag.valid <= in_valid;
			tag.sew   <= req.sew;
			tag.op    <= req.op;
			tag.addr  <= req.addr;
		end
	end

	// 64-bit elements are not supported by this unit
	assert property (@(posedge clk) disable iff (rst) in_valid |-> req.sew != SEW_64)
		else $error("request with reserved SEW code");

endmodule

//--- hdl/lane_mul_array.sv
/* lane multiplier array
   stage one forms byte and 17x17 piece products, stage two composes
   the piece products into signed 32x32 word products */

`timescale 1ns/1ps
`include "vmul_consts.svh"

module lane_mul_array import vmul_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  piece_ops_t   ops,
	input  mul_tag_t     tag_in,
	output product_vec_t prod,
	output mul_tag_t     tag_out
);

	// stage one results, full width before truncation
	logic [`VMUL_NUM_BYTES-1:0][2*`VMUL_BYTE_OP_W-1:0] byte_p_q;
	logic [`VMUL_NUM_PIECES/2-1:0][2*`VMUL_PIECE_W-1:0] ll_q;
	logic [`VMUL_NUM_PIECES/2-1:0][2*`VMUL_PIECE_W-1:0] lh_q;
	logic [`VMUL_NUM_PIECES/2-1:0][2*`VMUL_PIECE_W-1:0] hl_q;
	logic [`VMUL_NUM_PIECES/2-1:0][2*`VMUL_PIECE_W-1:0] hh_q;

	logic [`VMUL_NUM_PIECES/2-1:0][63:0] word_sum;
	mul_tag_t                            tag_mid;

	// stage one
	always_ff @(posedge clk) begin
		for (int j = 0; j < `VMUL_NUM_BYTES; j++) begin
			byte_p_q[j] <= $signed(ops.byte_a[j]) * $signed(ops.byte_b[j]);
		end

		// each pair of pieces is one 32-bit element
		for (int w = 0; w < `VMUL_NUM_PIECES/2; w++) begin
			ll_q[w] <= $signed(ops.a[2*w]) * $signed(ops.b[2*w]);
			lh_q[w] <= $signed(ops.a[2*w]) * $signed(ops.b[2*w+1]);
			hl_q[w] <= $signed(ops.a[2*w+1]) * $signed(ops.b[2*w]);
			hh_q[w] <= $signed(ops.a[2*w+1]) * $signed(ops.b[2*w+1]);
		end
	end

	// word product = hh<<32 + (lh+hl)<<16 + ll
	always_comb begin
		for (int w = 0; w < `VMUL_NUM_PIECES/2; w++) begin
			word_sum[w] = ($signed(hh_q[w]) <<< 32)
			            + (($signed(lh_q[w]) + $signed(hl_q[w])) <<< 16)
			            + $signed(ll_q[w]);
		end
	end

	// stage two
	always_ff @(posedge clk) begin
		for (int j = 0; j < `VMUL_NUM_BYTES; j++) begin
			prod.byte_prod[j] <= byte_p_q[j][15:0];
		end

		for (int w = 0; w < `VMUL_NUM_PIECES/2; w++) begin
			prod.half_prod[2*w]   <= ll_q[w][31:0]; // sew16 uses the diagonal products
			prod.half_prod[2*w+1] <= hh_q[w][31:0];
			prod.word_prod[w]     <= word_sum[w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_mid <= '0;
			tag_out <= '0;
		end else begin
			tag_mid <= tag_in;
			tag_out <= tag_mid;
		end
	end

	// word composition takes the low piece of a 32-bit element as unsigned
	assert property (@(posedge clk) disable iff (rst)
		tag_in.valid && tag_in.sew == SEW_32 |->
			!ops.a[0][`VMUL_PIECE_W-1] && !ops.a[2][`VMUL_PIECE_W-1] &&
			!ops.b[0][`VMUL_PIECE_W-1] && !ops.b[2][`VMUL_PIECE_W-1])
		else $error("low piece of a 32-bit element arrived sign-extended");

endmodule

//--- hdl/result_select.sv
/* result select stage
   picks the low or high half of every lane product by opcode and
   element width, registers vector, address and valid */

`timescale 1ns/1ps
`include "vmul_consts.svh"

module result_select import vmul_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  product_vec_t            prod,
	input  mul_tag_t                tag,
	output logic                    out_valid,
	output logic [`VMUL_DATA_W-1:0] out_vec,
	output logic [`VMUL_ADDR_W-1:0] out_addr
);

	logic                    low_half;
	logic [`VMUL_DATA_W-1:0] vec_d;

	assign low_half = (tag.op == OP_MUL);

	always_comb begin
		vec_d = '0;
		case (tag.sew)
			SEW_8: begin
				for (int j = 0; j < `VMUL_NUM_BYTES; j++) begin
					vec_d[8*j +: 8] = low_half ? prod.byte_prod[j][7:0]
					                           : prod.byte_prod[j][15:8];
				end
			end
			SEW_16: begin
				for (int i = 0; i < `VMUL_NUM_PIECES; i++) begin
					vec_d[16*i +: 16] = low_half ? prod.half_prod[i][15:0]
					                             : prod.half_prod[i][31:16];
				end
			end
			SEW_32: begin
				for (int w = 0; w < `VMUL_NUM_PIECES/2; w++) begin
					vec_d[32*w +: 32] = low_half ? prod.word_prod[w][31:0]
					                             : prod.word_prod[w][63:32];
				end
			end
			default: vec_d = '0; // reserved sew
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_vec   <= '0;
			out_addr  <= '0;
		end else begin
			out_valid <= tag.valid;
			// hold the last result between pulses
			if (tag.valid) begin
				out_vec  <= vec_d;
				out_addr <= tag.addr;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid))
		else $error("out_valid unknown after reset");

endmodule

//--- hdl/vmul_top.sv
/* pipelined SIMD integer multiplier
   operand select, lane multiplier array and result select in a row,
   four register stages from request to result */

`timescale 1ns/1ps
`include "vmul_consts.svh"

module vmul_top import vmul_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  mul_req_t                req,
	output logic                    out_valid,
	output logic [`VMUL_DATA_W-1:0] out_vec,
	output logic [`VMUL_ADDR_W-1:0] out_addr
);

	piece_ops_t   ops;
	mul_tag_t     tag_sel;  // after operand select
	mul_tag_t     tag_mul;  // after both multiplier stages
	product_vec_t prod;

	// 1 cycle
	operand_select i_operand_select (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.req      (req),
		.ops      (ops),
		.tag      (tag_sel)
	);

	// 2 cycles
	lane_mul_array i_lane_mul_array (
		.clk     (clk),
		.rst     (rst),
		.ops     (ops),
		.tag_in  (tag_sel),
		.prod    (prod),
		.tag_out (tag_mul)
	);

	// 1 cycle, output registers
	result_select i_result_select (
		.clk       (clk),
		.rst       (rst),
		.prod      (prod),
		.tag       (tag_mul),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

endmodule

//--- dv/vmul_ref.svh
/* reference model of the vector multiplier
   per lane: extend both elements, multiply at double width, keep one half */

`ifndef VMUL_REF_SVH
`define VMUL_REF_SVH

function automatic logic [63:0] expected_product(
	input logic [63:0] a,
	input logic [63:0] b,
	input sew_e        sew,
	input mul_op_e     op
);
	int                  ew;
	logic                a_sgn;
	logic                b_sgn;
	logic [127:0]        mask;
	logic signed [127:0] ea;
	logic signed [127:0] eb;
	logic signed [127:0] p;
	logic [127:0]        lane;
	logic [63:0]         res;

	ew    = 8 << int'(sew);
	mask  = (128'd1 << ew) - 1;
	a_sgn = (op == OP_MULH) || (op == OP_MULHSU); // vec0 signed for mulh and mulhsu
	b_sgn = (op == OP_MULH);
	res   = '0;

	for (int i = 0; i < 64 / ew; i++) begin
		ea = ({64'd0, a} >> (i * ew)) & mask;
		eb = ({64'd0, b} >> (i * ew)) & mask;
		if (a_sgn && ea[ew-1])
			ea = ea | ~mask;
		if (b_sgn && eb[ew-1])
			eb = eb | ~mask;
		p = ea * eb; // double width is enough, 128 bits never wrap
		lane = (op == OP_MUL) ? p : (p >> ew);
		res  = res | 64'((lane & mask) << (i * ew));
	end
	return res;
endfunction

`endif

//--- dv/vmul_tb.sv
/* testbench for the pipelined SIMD multiplier
   random and corner-case requests, in-order scoreboard with a due cycle */

`timescale 1ns/1ps
`include "vmul_consts.svh"

module vmul_tb import vmul_pkg::*; ();

	typedef struct packed {
		logic [`VMUL_DATA_W-1:0] vec;
		logic [`VMUL_ADDR_W-1:0] addr;
		int unsigned             due;
	} expect_t;

	// 30 low, 6 signed extremes, 30 high forms, 300 stream, 100 with gaps
	localparam int num_txn       = 466;
	localparam int timeout_limit = 20 + 2 * num_txn;

	logic                    clk;
	logic                    rst;
	logic                    in_valid;
	mul_req_t                req;
	logic                    out_valid;
	logic [`VMUL_DATA_W-1:0] out_vec;
	logic [`VMUL_ADDR_W-1:0] out_addr;

	expect_t     sb_q[$];
	int unsigned cycle = 0;
	int          sent = 0;
	int          checked = 0;
	sew_e        sew_list[3] = '{SEW_8, SEW_16, SEW_32};

	`include "vmul_ref.svh"

	vmul_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at cycle %0d", cycle);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_run("value mismatch");
		end
	endtask

	always @(posedge clk) begin
		if (cycle >= timeout_limit)
			stop_run($sformatf("timeout: test did not finish within %0d cycles", cycle));
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (out_valid === 1'b1) begin
			if (sb_q.size() == 0) begin
				stop_run("out_valid pulse with no request pending");
			end else begin
				e = sb_q.pop_front();
				check_value("out_valid cycle", 64'(cycle), 64'(e.due));
				check_value("out_vec", out_vec, e.vec);
				check_value("out_addr", 64'(out_addr), 64'(e.addr));
				checked++;
			end
		end else begin
			check_value("out_valid", 64'(out_valid), 64'd0); // catches X too
			if (sb_q.size() != 0 && sb_q[0].due <= cycle)
				stop_run("expected output did not appear in time");
		end
	end

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic sew_e rand_sew();
		logic [1:0] code;
		code = 2'($urandom_range(2));
		return sew_e'(code);
	endfunction

	function automatic mul_op_e rand_op();
		logic [1:0] code;
		code = 2'($urandom_range(3));
		return mul_op_e'(code);
	endfunction

	// same element in every lane
	function automatic logic [63:0] splat(input sew_e sew, input logic [31:0] elem);
		int          ew;
		logic [63:0] res;
		ew  = 8 << int'(sew);
		res = '0;
		for (int i = 0; i < 64 / ew; i++)
			res = res | (({32'd0, elem} & ((64'd1 << ew) - 1)) << (i * ew));
		return res;
	endfunction

	task automatic send(input logic [63:0] v0, input logic [63:0] v1,
	                    input sew_e sew, input mul_op_e op);
		expect_t e;
		req.vec0 = v0;
		req.vec1 = v1;
		req.sew  = sew;
		req.op   = op;
		req.addr = $urandom;
		in_valid = 1'b1;
		e.vec  = expected_product(v0, v1, sew, op);
		e.addr = req.addr;
		e.due  = cycle + `VMUL_LATENCY; // falling edge after the fourth rising edge
		sb_q.push_back(e);
		sent++;
		@(posedge clk);
		#1;
	endtask

	// junk on the request bus, strobe low
	task automatic idle();
		in_valid = 1'b0;
		req      = {rand64(), rand64(), rand_sew(), rand_op(), 32'($urandom)};
		@(posedge clk);
		#1;
	endtask

	initial begin
		int          ew;
		logic [31:0] min_s;
		logic [31:0] max_s;

		void'($urandom(74658));
		rst      = 1'b1;
		in_valid = 1'b1; // live strobe and junk request under reset
		req      = {rand64(), rand64(), rand_sew(), rand_op(), 32'($urandom)};
		repeat (10) @(posedge clk);
		#1;
		rst      = 1'b0;
		in_valid = 1'b0;

		foreach (sew_list[k])
			repeat (10) send(rand64(), rand64(), sew_list[k], OP_MUL);

		foreach (sew_list[k]) begin
			ew    = 8 << k;
			min_s = 32'd1 << (ew - 1);
			max_s = min_s - 1;
			send(splat(sew_list[k], min_s), splat(sew_list[k], min_s), sew_list[k], OP_MULH);
			send(splat(sew_list[k], '1), splat(sew_list[k], max_s), sew_list[k], OP_MULH);
		end

		foreach (sew_list[k]) begin
			repeat (4) send(rand64(), rand64(), sew_list[k], OP_MULHU);
			send('1, '1, sew_list[k], OP_MULHU);
			repeat (4) send(rand64(), rand64(), sew_list[k], OP_MULHSU);
			send('1, '1, sew_list[k], OP_MULHSU);
		end

		repeat (300) send(rand64(), rand64(), rand_sew(), rand_op());

		repeat (100) begin
			repeat ($urandom_range(2)) idle();
			send(rand64(), rand64(), rand_sew(), rand_op());
		end

		in_valid = 1'b0;
		while (sb_q.size() != 0)
			@(posedge clk);
		repeat (8) idle(); // no stray pulses after the last result

		if (sent != num_txn || checked != sent || sb_q.size() != 0) begin
			stop_run($sformatf("sent %0d requests but checked %0d results", sent, checked));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- verilog.f
+incdir+hdl
+incdir+dv
hdl/vmul_pkg.sv
hdl/operand_select.sv
hdl/lane_mul_array.sv
hdl/result_select.sv
hdl/vmul_top.sv
dv/vmul_tb.sv

//--- Makefile
# Verilator build and run of the vector multiplier testbench

VERILATOR ?= verilator
TOP       ?= vmul_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed, run ended without a pass line"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
